//--- files.f
+incdir+tests
rtl/ising_pkg.sv
rtl/ising_l1_mem.sv
rtl/ising_cmd_decode.sv
rtl/ising_anneal_ctrl.sv
rtl/ising_spin_array.sv
rtl/ising_energy_eval.sv
rtl/ising_core.sv
tests/tb_ising_core.sv

//--- run.sh
#!/usr/bin/env bash
# builds the ising core testbench with verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_ising_core -f files.f -o sim_ising_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_ising_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

//--- tests/ising_tb_model.svh
// reference model of the spin array rules for local field, energy and masked update
`ifndef ISING_TB_MODEL_SVH
`define ISING_TB_MODEL_SVH

typedef logic [NUM_SPIN-1:0][NUM_SPIN*BIT_J-1:0] j_matrix_t; // row i at index i

// field(i) = h(i) + sum over j of J(i,j) s(j), diagonal included
function automatic int model_field(input int i, input logic [NUM_SPIN-1:0] s,
                                   input j_matrix_t jm, input host_data_t h);
    logic signed [BIT_J-1:0] jij;
    logic signed [BIT_H-1:0] hi;
    int                      acc;
    hi  = h[i*BIT_H +: BIT_H];
    acc = int'(hi);
    for (int j = 0; j < NUM_SPIN; j++) begin
        jij = jm[i][j*BIT_J +: BIT_J];
        acc = s[j] ? acc + int'(jij) : acc - int'(jij); // bit 1 is +1
    end
    return acc;
endfunction

// energy = -sum s(i) field(i)
function automatic int model_energy(input logic [NUM_SPIN-1:0] s, input j_matrix_t jm,
                                    input host_data_t h);
    int e;
    int f;
    e = 0;
    for (int i = 0; i < NUM_SPIN; i++) begin
        f = model_field(i, s, jm, h);
        e = s[i] ? e - f : e + f;
    end
    return e;
endfunction

// masked spins follow the sign of the old field, zero counts as +1
function automatic logic [NUM_SPIN-1:0] model_update(input logic [NUM_SPIN-1:0] s,
        input logic [NUM_SPIN-1:0] mask, input j_matrix_t jm, input host_data_t h);
    logic [NUM_SPIN-1:0] s_new;
    s_new = s;
    for (int i = 0; i < NUM_SPIN; i++) begin
        if (mask[i]) s_new[i] = (model_field(i, s, jm, h) >= 0);
    end
    return s_new;
endfunction

`endif

//--- tests/tb_ising_core.sv
// testbench for the ising annealing core, checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_ising_core;
    import ising_pkg::*;

    `include "ising_tb_model.svh"

    localparam int NumRuns    = 11;
    // host writes for a full load plus one run at the deepest flip count
    localparam int WorstRun   = 2 * (NUM_SPIN + FLIP_DEPTH + 4) + 2 * NUM_SPIN + 2
                                + FLIP_DEPTH * (NUM_SPIN + 5);
    localparam int CycleLimit = NumRuns * WorstRun + 20;
    localparam int EnergyMax  = 2 ** ($bits(energy_t) - 1) - 1;
    localparam host_data_t HandRows [NUM_SPIN] = '{
        32'h1f2e_3d4c, 32'h0a7b_6c5d, 32'h9e8f_7061, 32'h2233_4455,
        32'hfedc_ba98, 32'h7177_1e2d, 32'h8a0b_c3f4, 32'h5d6e_7f01
    };

    logic                clk;
    logic                reset;
    logic                host_we;
    host_addr_t          host_addr;
    host_data_t          host_wdata;
    logic                busy;
    logic                done;
    logic [NUM_SPIN-1:0] spins;
    energy_t             energy;
    energy_t             best_energy;
    logic [NUM_SPIN-1:0] best_spins;

    // model copy of what the host has written
    j_matrix_t           j_model;
    logic [NUM_SPIN-1:0] mask_model [FLIP_DEPTH];
    host_data_t          h_model;
    logic [NUM_SPIN-1:0] init_model;
    int                  count_model;

    logic [NUM_SPIN-1:0] exp_spins;
    logic [NUM_SPIN-1:0] exp_best_spins;
    int                  exp_energy;
    int                  exp_best;
    int                  exp_steps;
    int                  checks = 0;
    int                  errors = 0;
    int                  cycles = 0;

    ising_core #(
        .NumSpin  (NUM_SPIN  ),
        .BitJ     (BIT_J     ),
        .BitH     (BIT_H     ),
        .FlipDepth(FLIP_DEPTH)
    ) UUT (
        .clk_i        (clk        ),
        .reset_i      (reset      ),
        .host_we_i    (host_we    ),
        .host_addr_i  (host_addr  ),
        .host_wdata_i (host_wdata ),
        .busy_o       (busy       ),
        .done_o       (done       ),
        .spins_o      (spins      ),
        .energy_o     (energy     ),
        .best_energy_o(best_energy),
        .best_spins_o (best_spins )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("timeout, the core did not finish within %0d cycles", CycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // host access and model bookkeeping
    ////////////////////////////////////////////////////////////////////////////
    task automatic host_write(input host_addr_t addr, input host_data_t data);
        @(posedge clk);
        host_we    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= data;
        @(posedge clk);
        host_we    <= 1'b0;
    endtask

    task automatic set_j_row(input int i, input host_data_t row);
        host_write(host_addr_t'(ADDR_J_BASE + i), row);
        j_model[i] = row;
    endtask

    task automatic set_mask(input int k, input logic [NUM_SPIN-1:0] m);
        host_write(host_addr_t'(ADDR_FLIP_BASE + k), host_data_t'(m));
        mask_model[k] = m;
    endtask

    task automatic set_config(input host_data_t h, input logic [NUM_SPIN-1:0] s0,
                              input int count);
        host_write(ADDR_HBIAS, h);
        host_write(ADDR_SPIN_INIT, host_data_t'(s0));
        host_write(ADDR_FLIP_COUNT, host_data_t'(count));
        h_model     = h;
        init_model  = s0;
        count_model = count;
    endtask

    task automatic load_random(input int n);
        for (int i = 0; i < NUM_SPIN; i++) set_j_row(i, $urandom());
        for (int k = 0; k < n; k++) set_mask(k, NUM_SPIN'($urandom()));
        set_config($urandom(), NUM_SPIN'($urandom()), n);
    endtask

    // walk the flip steps and keep the strictly lower energies
    task automatic predict_run;
        int e;
        exp_spins      = init_model;
        exp_best       = EnergyMax;
        exp_best_spins = '0;
        exp_steps      = (count_model > FLIP_DEPTH) ? FLIP_DEPTH : count_model;
        for (int k = 0; k < exp_steps; k++) begin
            exp_spins  = model_update(exp_spins, mask_model[k], j_model, h_model);
            e          = model_energy(exp_spins, j_model, h_model);
            exp_energy = e;
            if (e < exp_best) begin
                exp_best       = e;
                exp_best_spins = exp_spins;
            end
        end
    endtask

    task automatic wait_busy;
        @(negedge clk);
        while (!busy) @(negedge clk);
    endtask

    task automatic wait_done;
        @(negedge clk);
        while (!done) @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input int got, input int want);
        checks++;
        assert (got == want) else begin
            errors++;
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, want);
        end
    endtask

    task automatic check_run;
        check_value("busy_o", int'(busy), 0); // falls together with done
        check_value("spins_o", int'(spins), int'(exp_spins));
        if (exp_steps > 0) check_value("energy_o", int'(energy), exp_energy);
        check_value("best_energy_o", int'(best_energy), exp_best);
        check_value("best_spins_o", int'(best_spins), int'(exp_best_spins));
    endtask

    task automatic run_and_check;
        predict_run();
        host_write(ADDR_CTRL, 32'h1);
        wait_done();
        check_run();
    endtask

    initial begin
        void'($urandom(32'h2e06_374c));
        reset      = 1'b1;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("busy_o", int'(busy), 0);
        check_value("done_o", int'(done), 0);
        check_value("spins_o", int'(spins), 0);
        check_value("best_energy_o", int'(best_energy), EnergyMax);

        // hand-picked problem with one all-ones mask
        for (int i = 0; i < NUM_SPIN; i++) set_j_row(i, HandRows[i]);
        set_mask(0, '1);
        set_config(32'h1e0f_2d3c, 8'h5a, 1);
        run_and_check();

        repeat (5) begin
            load_random(6);
            run_and_check();
        end

        set_config(h_model, NUM_SPIN'($urandom()), 0); // no flip steps at all
        run_and_check();

        // everything written during the run must be dropped
        load_random(6);
        predict_run();
        host_write(ADDR_CTRL, 32'h1);
        wait_busy();
        host_write(host_addr_t'(ADDR_J_BASE + 2), $urandom());
        host_write(host_addr_t'(ADDR_FLIP_BASE + 1), $urandom());
        host_write(ADDR_HBIAS, $urandom());
        host_write(ADDR_SPIN_INIT, $urandom());
        host_write(ADDR_FLIP_COUNT, 32'h0);
        host_write(ADDR_CTRL, 32'h1);
        wait_done();
        check_run();
        run_and_check(); // memories still hold the old contents

        // J(1,0) = -6 and h(0) = +1, so setting spin 0 raises the energy
        for (int i = 0; i < NUM_SPIN; i++) set_j_row(i, (i == 1) ? 32'h0000_000a : 32'h0);
        set_mask(0, '0);
        set_mask(1, 8'h01);
        set_config(32'h0000_0001, 8'hfe, 1);
        run_and_check();
        check_value("spins_o", int'(spins), int'(init_model));
        set_config(32'h0000_0001, 8'hfe, 2);
        run_and_check();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/ising_core.sv
// ising annealing core top with decoder, l1 memories, controller, spin array and evaluator
`timescale 1ns/1ps
`default_nettype none

module ising_core #(
    parameter int NumSpin   = ising_pkg::NUM_SPIN,
    parameter int BitJ      = ising_pkg::BIT_J,
    parameter int BitH      = ising_pkg::BIT_H,
    parameter int FlipDepth = ising_pkg::FLIP_DEPTH
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  host_we_i,
    input  ising_pkg::host_addr_t host_addr_i,
    input  ising_pkg::host_data_t host_wdata_i,
    output logic                  busy_o,
    output logic                  done_o,
    output logic [NumSpin-1:0]    spins_o,
    output ising_pkg::energy_t    energy_o,
    output ising_pkg::energy_t    best_energy_o,
    output logic [NumSpin-1:0]    best_spins_o
);
    import ising_pkg::*;

    localparam int FieldWidth = field_width(BitJ, BitH, NumSpin);

    // decode outputs
    logic       j_we, flip_we, start;
    host_addr_t mem_waddr;
    host_data_t mem_wdata, hbias, spin_init, flip_count;

    // memory read side
    logic                         j_ren, flip_ren;
    logic [$clog2(NumSpin)-1:0]   j_raddr;
    logic [$clog2(FlipDepth)-1:0] flip_raddr;
    logic [NumSpin*BitJ-1:0]      j_rdata;
    logic [NumSpin-1:0]           flip_rdata;

    // array and evaluator control
    logic [NumSpin-1:0]            j_wwl, flip_mask;
    logic                          spin_wwl, update_en;
    logic                          eval_start, eval_done, clear_best;
    logic [NumSpin*FieldWidth-1:0] fields;

    ////////////////////////////////////////////////////////////////////////////
    // host decode and l1 memories
    ////////////////////////////////////////////////////////////////////////////
    ising_cmd_decode u_cmd_decode (
        .clk_i       (clk_i       ),
        .reset_i     (reset_i     ),
        .host_we_i   (host_we_i   ),
        .host_addr_i (host_addr_i ),
        .host_wdata_i(host_wdata_i),
        .busy_i      (busy_o      ),
        .j_we_o      (j_we        ),
        .flip_we_o   (flip_we     ),
        .mem_waddr_o (mem_waddr   ),
        .mem_wdata_o (mem_wdata   ),
        .hbias_o     (hbias       ),
        .spin_init_o (spin_init   ),
        .flip_count_o(flip_count  ),
        .start_o     (start       )
    );

    ising_l1_mem #(.Width(NumSpin*BitJ), .Depth(NumSpin)) i_l1_mem_j (
        .clk_i  (clk_i                             ),
        .we_i   (j_we                              ),
        .waddr_i(mem_waddr[$clog2(NumSpin)-1:0]    ),
        .wdata_i(mem_wdata[NumSpin*BitJ-1:0]       ),
        .ren_i  (j_ren                             ),
        .raddr_i(j_raddr                           ),
        .rdata_o(j_rdata                           )
    );

    ising_l1_mem #(.Width(NumSpin), .Depth(FlipDepth)) i_l1_mem_flip (
        .clk_i  (clk_i                             ),
        .we_i   (flip_we                           ),
        .waddr_i(mem_waddr[$clog2(FlipDepth)-1:0]  ),
        .wdata_i(mem_wdata[NumSpin-1:0]            ),
        .ren_i  (flip_ren                          ),
        .raddr_i(flip_raddr                        ),
        .rdata_o(flip_rdata                        )
    );

    ////////////////////////////////////////////////////////////////////////////
    // controller, spin array and energy evaluation
    ////////////////////////////////////////////////////////////////////////////
    ising_anneal_ctrl #(.NumSpin(NumSpin), .FlipDepth(FlipDepth)) u_anneal_ctrl (
        .clk_i       (clk_i       ),
        .reset_i     (reset_i     ),
        .start_i     (start       ),
        .flip_count_i(flip_count  ),
        .j_ren_o     (j_ren       ),
        .j_raddr_o   (j_raddr     ),
        .flip_ren_o  (flip_ren    ),
        .flip_raddr_o(flip_raddr  ),
        .flip_rdata_i(flip_rdata  ),
        .j_wwl_o     (j_wwl       ),
        .spin_wwl_o  (spin_wwl    ),
        .update_en_o (update_en   ),
        .flip_mask_o (flip_mask   ),
        .eval_start_o(eval_start  ),
        .eval_done_i (eval_done   ),
        .clear_best_o(clear_best  ),
        .busy_o      (busy_o      ),
        .done_o      (done_o      )
    );

    ising_spin_array #(.NumSpin(NumSpin), .BitJ(BitJ), .BitH(BitH)) u_spin_array (
        .clk_i       (clk_i                     ),
        .reset_i     (reset_i                   ),
        .j_wwl_i     (j_wwl                     ), // row data straight from j memory
        .j_row_i     (j_rdata                   ),
        .hbias_i     (hbias[NumSpin*BitH-1:0]   ),
        .spin_wwl_i  (spin_wwl                  ),
        .spin_init_i (spin_init[NumSpin-1:0]    ),
        .update_en_i (update_en                 ),
        .flip_mask_i (flip_mask                 ),
        .spins_o     (spins_o                   ),
        .fields_o    (fields                    )
    );

    ising_energy_eval #(.NumSpin(NumSpin), .FieldWidth(FieldWidth)) u_energy_eval (
        .clk_i        (clk_i        ),
        .reset_i      (reset_i      ),
        .start_i      (eval_start   ),
        .clear_best_i (clear_best   ),
        .spins_i      (spins_o      ),
        .fields_i     (fields       ),
        .done_o       (eval_done    ),
        .energy_o     (energy_o     ),
        .best_energy_o(best_energy_o),
        .best_spins_o (best_spins_o )
    );

endmodule

`default_nettype wire

//--- rtl/ising_energy_eval.sv
// serial energy evaluator with best energy and best spin tracking
`timescale 1ns/1ps
`default_nettype none

module ising_energy_eval #(
    parameter int NumSpin    = ising_pkg::NUM_SPIN,
    parameter int FieldWidth = 8
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          start_i,
    input  logic                          clear_best_i,
    input  logic [NumSpin-1:0]            spins_i,
    input  logic [NumSpin*FieldWidth-1:0] fields_i,
    output logic                          done_o,
    output ising_pkg::energy_t            energy_o,
    output ising_pkg::energy_t            best_energy_o,
    output logic [NumSpin-1:0]            best_spins_o
);
    import ising_pkg::*;

    localparam int      IdxW      = $clog2(NumSpin);
    localparam energy_t EnergyMax = {1'b0, {($bits(energy_t) - 1){1'b1}}};

    logic [NumSpin-1:0]            spin_q;  // snapshot taken on start
    logic [NumSpin*FieldWidth-1:0] field_q;
    logic [IdxW-1:0]               idx_q;
    logic                          active_q;
    energy_t                       acc_q;
    energy_t                       term;
    energy_t                       sum;
    logic signed [FieldWidth-1:0]  field_cur;

    // energy = -sum s(i) field(i)
    assign field_cur = field_q[idx_q*FieldWidth +: FieldWidth];
    assign term      = spin_q[idx_q] ? -energy_t'(field_cur) : energy_t'(field_cur);
    assign sum       = acc_q + term;
    assign done_o    = active_q && (idx_q == IdxW'(NumSpin - 1));

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            spin_q  <= spins_i;
            field_q <= fields_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            active_q      <= 1'b0;
            idx_q         <= '0;
            acc_q         <= '0;
            energy_o      <= '0;
            best_energy_o <= EnergyMax;
            best_spins_o  <= '0;
        end else begin
            if (start_i) begin
                active_q <= 1'b1;
                idx_q    <= '0;
                acc_q    <= '0;
            end else if (active_q) begin
                acc_q <= sum;
                idx_q <= idx_q + IdxW'(1);
                if (done_o) begin
                    active_q <= 1'b0;
                    energy_o <= sum;
                    if (sum < best_energy_o) begin // strictly lower only
                        best_energy_o <= sum;
                        best_spins_o  <= spin_q;
                    end
                end
            end
            if (clear_best_i) begin
                best_energy_o <= EnergyMax;
                best_spins_o  <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/ising_spin_array.sv
// digital spin array holding couplings and spins, with local fields and masked updates
`timescale 1ns/1ps
`default_nettype none

module ising_spin_array #(
    parameter int  NumSpin    = ising_pkg::NUM_SPIN,
    parameter int  BitJ       = ising_pkg::BIT_J,
    parameter int  BitH       = ising_pkg::BIT_H,
    localparam int FieldWidth = ising_pkg::field_width(BitJ, BitH, NumSpin)
) (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  logic [NumSpin-1:0]              j_wwl_i,    // one-hot row write
    input  logic [NumSpin*BitJ-1:0]         j_row_i,
    input  logic [NumSpin*BitH-1:0]         hbias_i,
    input  logic                            spin_wwl_i,
    input  logic [NumSpin-1:0]              spin_init_i,
    input  logic                            update_en_i,
    input  logic [NumSpin-1:0]              flip_mask_i,
    output logic [NumSpin-1:0]              spins_o,
    output logic [NumSpin*FieldWidth-1:0]   fields_o
);

    logic [NumSpin*BitJ-1:0] j_q [NumSpin]; // coupling rows
    logic [NumSpin-1:0]      spins_q;       // 1 is +1, 0 is -1

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NumSpin; i++) begin
            if (j_wwl_i[i]) j_q[i] <= j_row_i;
        end
    end

    // field(i) = h(i) + sum_j J(i,j) s(j)
    always_comb begin : field_calc
        logic signed [FieldWidth-1:0] acc;
        logic signed [BitJ-1:0]       jij;
        logic signed [BitH-1:0]       hi;
        for (int i = 0; i < NumSpin; i++) begin
            hi  = hbias_i[i*BitH +: BitH];
            acc = FieldWidth'(hi);
            for (int j = 0; j < NumSpin; j++) begin
                jij = j_q[i][j*BitJ +: BitJ];
                acc = spins_q[j] ? acc + FieldWidth'(jij) : acc - FieldWidth'(jij);
            end
            fields_o[i*FieldWidth +: FieldWidth] = acc;
        end
    end

    // masked spins take the sign of their field, all fields from the old state
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            spins_q <= '0;
        end else if (spin_wwl_i) begin
            spins_q <= spin_init_i;
        end else if (update_en_i) begin
            for (int i = 0; i < NumSpin; i++) begin
                if (flip_mask_i[i]) spins_q[i] <= !fields_o[i*FieldWidth + FieldWidth - 1];
            end
        end
    end

    assign spins_o = spins_q;

endmodule

`default_nettype wire

//--- rtl/ising_anneal_ctrl.sv
// annealing fsm sequencing coupling load, spin init, flip steps and energy evaluation
`timescale 1ns/1ps
`default_nettype none

module ising_anneal_ctrl #(
    parameter int NumSpin   = ising_pkg::NUM_SPIN,
    parameter int FlipDepth = ising_pkg::FLIP_DEPTH
) (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         start_i,
    input  ising_pkg::host_data_t        flip_count_i,
    output logic                         j_ren_o,
    output logic [$clog2(NumSpin)-1:0]   j_raddr_o,
    output logic                         flip_ren_o,
    output logic [$clog2(FlipDepth)-1:0] flip_raddr_o,
    input  logic [NumSpin-1:0]           flip_rdata_i,
    output logic [NumSpin-1:0]           j_wwl_o,
    output logic                         spin_wwl_o,
    output logic                         update_en_o,
    output logic [NumSpin-1:0]           flip_mask_o,
    output logic                         eval_start_o,
    input  logic                         eval_done_i,
    output logic                         clear_best_o,
    output logic                         busy_o,
    output logic                         done_o
);
    import ising_pkg::*;

    localparam int RowW  = $clog2(NumSpin);
    localparam int StepW = $clog2(FlipDepth);

    anneal_state_e    state_q;
    logic [RowW-1:0]  row_q;
    logic [StepW-1:0] step_q;
    logic             phase_q; // second cycle of a two-cycle access
    logic             idle;
    logic             last_step;
    host_data_t       steps;

    // clip the flip count to the mask memory depth
    assign steps     = (flip_count_i > host_data_t'(FlipDepth)) ? host_data_t'(FlipDepth)
                                                                : flip_count_i;
    assign last_step = host_data_t'(step_q) == steps - host_data_t'(1);
    assign idle      = (state_q == ST_IDLE) || (state_q == ST_DONE);

    ////////////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            row_q   <= '0;
            step_q  <= '0;
            phase_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE, ST_DONE: begin
                    state_q <= start_i ? ST_LOAD_J : ST_IDLE;
                    row_q   <= '0;
                    phase_q <= 1'b0;
                end
                ST_LOAD_J: begin // read a row, then write it into the array
                    phase_q <= !phase_q;
                    if (phase_q) begin
                        row_q <= row_q + RowW'(1);
                        if (row_q == RowW'(NumSpin - 1)) state_q <= ST_INIT;
                    end
                end
                ST_INIT: begin
                    step_q  <= '0;
                    state_q <= (steps == '0) ? ST_DONE : ST_FLIP_RD;
                end
                ST_FLIP_RD: begin
                    phase_q <= !phase_q;
                    if (phase_q) state_q <= ST_UPDATE;
                end
                ST_UPDATE: state_q <= ST_EVAL;
                ST_EVAL: begin
                    phase_q <= 1'b1; // eval_start only in the first cycle
                    if (eval_done_i) begin
                        phase_q <= 1'b0;
                        step_q  <= step_q + StepW'(1);
                        state_q <= last_step ? ST_DONE : ST_FLIP_RD;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // decoded strobes
    assign j_ren_o      = (state_q == ST_LOAD_J) && !phase_q;
    assign j_raddr_o    = row_q;
    assign j_wwl_o      = ((state_q == ST_LOAD_J) && phase_q) ? (NumSpin'(1) << row_q) : '0;
    assign spin_wwl_o   = state_q == ST_INIT;
    assign flip_ren_o   = (state_q == ST_FLIP_RD) && !phase_q;
    assign flip_raddr_o = step_q;
    assign update_en_o  = state_q == ST_UPDATE;
    assign flip_mask_o  = update_en_o ? flip_rdata_i : '0;
    assign eval_start_o = (state_q == ST_EVAL) && !phase_q;
    assign clear_best_o = idle && start_i;
    assign busy_o       = !idle;
    assign done_o       = state_q == ST_DONE;

endmodule

`default_nettype wire

//--- rtl/ising_cmd_decode.sv
// host write decoder for memory strobes, configuration registers and start
`timescale 1ns/1ps
`default_nettype none

module ising_cmd_decode (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   host_we_i,
    input  ising_pkg::host_addr_t  host_addr_i,
    input  ising_pkg::host_data_t  host_wdata_i,
    input  logic                   busy_i,
    output logic                   j_we_o,
    output logic                   flip_we_o,
    output ising_pkg::host_addr_t  mem_waddr_o,
    output ising_pkg::host_data_t  mem_wdata_o,
    output ising_pkg::host_data_t  hbias_o,
    output ising_pkg::host_data_t  spin_init_o,
    output ising_pkg::host_data_t  flip_count_o,
    output logic                   start_o
);
    import ising_pkg::*;

    logic accept;
    logic hit_j;
    logic hit_flip;

    // start_o is blocked too, busy is not up yet in that cycle
    assign accept   = host_we_i && !busy_i && !start_o;
    assign hit_j    = host_addr_i < ADDR_FLIP_BASE;
    assign hit_flip = (host_addr_i >= ADDR_FLIP_BASE) && (host_addr_i < ADDR_HBIAS);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            j_we_o       <= 1'b0;
            flip_we_o    <= 1'b0;
            start_o      <= 1'b0;
            hbias_o      <= '0;
            spin_init_o  <= '0;
            flip_count_o <= '0;
        end else begin
            j_we_o    <= accept && hit_j;
            flip_we_o <= accept && hit_flip;
            start_o   <= accept && (host_addr_i == ADDR_CTRL) && host_wdata_i[0];
            if (accept && host_addr_i == ADDR_HBIAS)      hbias_o      <= host_wdata_i;
            if (accept && host_addr_i == ADDR_SPIN_INIT)  spin_init_o  <= host_wdata_i;
            if (accept && host_addr_i == ADDR_FLIP_COUNT) flip_count_o <= host_wdata_i;
        end
    end

    // memory word offset and data, qualified by the strobes above
    always_ff @(posedge clk_i) begin
        if (accept) begin
            mem_waddr_o <= hit_j ? host_addr_i - ADDR_J_BASE : host_addr_i - ADDR_FLIP_BASE;
            mem_wdata_o <= host_wdata_i;
        end
    end

endmodule

`default_nettype wire

//--- rtl/ising_l1_mem.sv
// l1 memory with one host write port and a registered read port
`timescale 1ns/1ps
`default_nettype none

module ising_l1_mem #(
    parameter int Width = 32,
    parameter int Depth = 16
) (
    input  logic                     clk_i,
    input  logic                     we_i,
    input  logic [$clog2(Depth)-1:0] waddr_i,
    input  logic [Width-1:0]         wdata_i,
    input  logic                     ren_i,
    input  logic [$clog2(Depth)-1:0] raddr_i,
    output logic [Width-1:0]         rdata_o
);

    logic [Width-1:0] mem_q [Depth];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // read data holds until the next enable
    always_ff @(posedge clk_i) begin
        if (ren_i) begin
            rdata_o <= mem_q[raddr_i];
        end
    end

endmodule

`default_nettype wire

//--- rtl/ising_pkg.sv
// ising core package with default sizes, host types, address map and fsm states
`default_nettype none

package ising_pkg;

    // default core sizes
    localparam int NUM_SPIN   = 8;
    localparam int BIT_J      = 4; // signed coupling width
    localparam int BIT_H      = 4; // signed bias width
    localparam int FLIP_DEPTH = 16;

    typedef logic [7:0]         host_addr_t;
    typedef logic [31:0]        host_data_t;
    typedef logic signed [15:0] energy_t;

    // host address map
    localparam host_addr_t ADDR_J_BASE     = 8'h00; // rows 0x00..0x07
    localparam host_addr_t ADDR_FLIP_BASE  = 8'h10; // masks 0x10..0x1f
    localparam host_addr_t ADDR_HBIAS      = 8'h20;
    localparam host_addr_t ADDR_SPIN_INIT  = 8'h21;
    localparam host_addr_t ADDR_FLIP_COUNT = 8'h22;
    localparam host_addr_t ADDR_CTRL       = 8'h23; // bit 0 starts a run

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD_J,
        ST_INIT,
        ST_FLIP_RD,
        ST_UPDATE,
        ST_EVAL,
        ST_DONE
    } anneal_state_e;

    // local field width, room for num_spin couplings plus the bias
    function automatic int field_width(int bit_j, int bit_h, int num_spin);
        return ((bit_j > bit_h) ? bit_j : bit_h) + $clog2(num_spin) + 1;
    endfunction

endpackage

`default_nettype wire
